// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // Address and data widths of the fetch path
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [1:0]  axi_resp_t;

    // Program counter
    localparam addr_t RESET_PC = 32'h1c000000;
    localparam addr_t PC_STEP  = 32'd4;

    // Instruction buffer geometry
    localparam int IBUF_DEPTH = 8;
    localparam int IBUF_PTR_W = 3;
    // One bit wider than the pointers so a full buffer can be counted
    localparam int IBUF_CNT_W = 4;

    // AXI constants
    // Instruction access, secure, unprivileged
    localparam logic [2:0] AXI_PROT_INSTR = 3'b100;
    localparam axi_resp_t  RESP_OKAY      = 2'b00;

    // Read master states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

endpackage

// ==== source/mem_read_if.sv ====
`timescale 1ns/1ps

interface mem_read_if
    import fetch_pkg::*;
();

    // Request from the program counter unit
    logic   req_valid;
    addr_t  req_addr;
    logic   req_ready;

    // Response, single cycle pulse
    logic   rsp_valid;
    instr_t rsp_data;
    logic   rsp_err;

    modport requester (
        output req_valid, req_addr,
        input  req_ready, rsp_valid, rsp_data, rsp_err
    );

    modport server (
        input  req_valid, req_addr,
        output req_ready, rsp_valid, rsp_data, rsp_err
    );

endinterface

// ==== source/fetch_buf_if.sv ====
`timescale 1ns/1ps

interface fetch_buf_if
    import fetch_pkg::*;
();

    // Write side, driven by the program counter unit
    logic                  push;
    addr_t                 push_pc;
    instr_t                push_data;
    logic                  push_fault;
    logic                  flush;

    // Occupancy, used for fetch credit
    logic [IBUF_CNT_W-1:0] count;

    modport producer (
        output push, push_pc, push_data, push_fault, flush,
        input  count
    );

    modport store (
        input  push, push_pc, push_data, push_fault, flush,
        output count
    );

endinterface

// ==== source/axi_read_master.sv ====
`timescale 1ns/1ps

module axi_read_master
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    mem_read_if.server mem,

    // AXI4-Lite read channels
    output addr_t      araddr_o,
    output logic [2:0] arprot_o,
    output logic       arvalid_o,
    input  logic       arready_i,
    input  instr_t     rdata_i,
    input  axi_resp_t  rresp_i,
    input  logic       rvalid_i,
    output logic       rready_o
);

    rd_state_t state;
    addr_t     addr_q;
    logic      req_fire;
    logic      r_fire;

    logic      rsp_valid_q;
    instr_t    rsp_data_q;
    logic      rsp_err_q;

    // Only one read on the bus at a time
    assign mem.req_ready = (state == RD_IDLE);
    assign req_fire      = mem.req_valid && mem.req_ready;
    assign r_fire        = (state == RD_DATA) && rvalid_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (mem.req_valid) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready_i) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid_i) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Address stays stable for the whole AR phase
    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= mem.req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= r_fire;
        end
    end

    // Read data and error flag, captured on the R handshake
    always_ff @(posedge clk) begin
        if (r_fire) begin
            rsp_data_q <= rdata_i;
            rsp_err_q  <= (rresp_i != RESP_OKAY);
        end
    end

    assign araddr_o  = addr_q;
    assign arprot_o  = AXI_PROT_INSTR;
    assign arvalid_o = (state == RD_ADDR);
    assign rready_o  = (state == RD_DATA);

    assign mem.rsp_valid = rsp_valid_q;
    assign mem.rsp_data  = rsp_data_q;
    assign mem.rsp_err   = rsp_err_q;

endmodule

// ==== source/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
(
    input  logic           clk,
    input  logic           rst_i,

    // Backend redirect
    input  logic           redirect_valid_i,
    input  addr_t          redirect_pc_i,

    mem_read_if.requester  mem,
    fetch_buf_if.producer  buf_o
);

    addr_t                 pc;
    addr_t                 inflight_pc;
    logic                  redir_q;
    logic                  stale;
    logic [IBUF_CNT_W-1:0] outstanding;
    logic [IBUF_CNT_W-1:0] credit_used;
    logic                  req_fire;

    // Entries held plus reads that will still land in the buffer
    assign credit_used   = buf_o.count + outstanding;
    assign mem.req_valid = (credit_used < IBUF_CNT_W'(IBUF_DEPTH));
    assign mem.req_addr  = pc;
    assign req_fire      = mem.req_valid && mem.req_ready;

    // Redirect takes priority over sequential advance
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc <= {redirect_pc_i[31:2], 2'b00};
        end else if (req_fire) begin
            pc <= pc + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            redir_q <= 1'b0;
        end else begin
            redir_q <= redirect_valid_i;
        end
    end

    // Reads issued but not yet answered
    always_ff @(posedge clk) begin
        if (rst_i) begin
            outstanding <= '0;
        end else begin
            case ({req_fire, mem.rsp_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // At most one read in flight, so one flag covers it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            stale <= 1'b0;
        end else if (redir_q) begin
            // A response arriving right now is dropped below instead
            stale <= (outstanding != '0) && !mem.rsp_valid;
        end else if (mem.rsp_valid) begin
            stale <= 1'b0;
        end
    end

    // Address of the read on the bus, paired with its response
    always_ff @(posedge clk) begin
        if (req_fire) begin
            inflight_pc <= pc;
        end
    end

    assign buf_o.push       = mem.rsp_valid && !stale && !redir_q;
    assign buf_o.push_pc    = inflight_pc;
    assign buf_o.push_data  = mem.rsp_data;
    assign buf_o.push_fault = mem.rsp_err;
    assign buf_o.flush      = redir_q;

endmodule

// ==== source/instr_buffer.sv ====
`timescale 1ns/1ps

module instr_buffer
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    fetch_buf_if.store buf_i,

    // Backend side
    output logic       instr_valid_o,
    output addr_t      instr_pc_o,
    output instr_t     instr_data_o,
    output logic       instr_fault_o,
    input  logic       instr_ready_i
);

    // Entry storage
    addr_t                 pc_mem    [IBUF_DEPTH];
    instr_t                data_mem  [IBUF_DEPTH];
    logic                  fault_mem [IBUF_DEPTH];

    logic [IBUF_PTR_W-1:0] wr_ptr;
    logic [IBUF_PTR_W-1:0] rd_ptr;
    logic [IBUF_CNT_W-1:0] count;
    logic                  pop;

    assign pop = instr_valid_o && instr_ready_i;

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (buf_i.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (buf_i.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({buf_i.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer never pushes into a full buffer
    always_ff @(posedge clk) begin
        if (buf_i.push && !buf_i.flush) begin
            pc_mem[wr_ptr]    <= buf_i.push_pc;
            data_mem[wr_ptr]  <= buf_i.push_data;
            fault_mem[wr_ptr] <= buf_i.push_fault;
        end
    end

    assign buf_i.count = count;

    // Head of the queue
    assign instr_valid_o = (count != '0);
    assign instr_pc_o    = pc_mem[rd_ptr];
    assign instr_data_o  = data_mem[rd_ptr];
    assign instr_fault_o = fault_mem[rd_ptr];

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    // Redirect from the backend
    input  logic       redirect_valid_i,
    input  addr_t      redirect_pc_i,

    // AXI4-Lite read master
    output addr_t      araddr_o,
    output logic [2:0] arprot_o,
    output logic       arvalid_o,
    input  logic       arready_i,
    input  instr_t     rdata_i,
    input  axi_resp_t  rresp_i,
    input  logic       rvalid_i,
    output logic       rready_o,

    // Instructions to the backend
    output logic       instr_valid_o,
    output addr_t      instr_pc_o,
    output instr_t     instr_data_o,
    output logic       instr_fault_o,
    input  logic       instr_ready_i
);

    // PC unit <-> AXI master
    mem_read_if  mem_rd ();

    // PC unit <-> instruction buffer
    fetch_buf_if fbuf ();

    axi_read_master u_axi_read_master (
        .clk       (clk),
        .rst_i     (rst_i),
        .mem       (mem_rd.server),
        .araddr_o  (araddr_o),
        .arprot_o  (arprot_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rresp_i   (rresp_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o)
    );

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .mem              (mem_rd.requester),
        .buf_o            (fbuf.producer)
    );

    instr_buffer u_instr_buffer (
        .clk           (clk),
        .rst_i         (rst_i),
        .buf_i         (fbuf.store),
        .instr_valid_o (instr_valid_o),
        .instr_pc_o    (instr_pc_o),
        .instr_data_o  (instr_data_o),
        .instr_fault_o (instr_fault_o),
        .instr_ready_i (instr_ready_i)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    // 40 ns period
    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

// ==== bench/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int          CLK_PERIOD_NS    = 40;
    localparam int          RESET_CYCLES     = 16;
    localparam int          RUN_A_COUNT      = 100;
    localparam int          STALL_CYCLES     = 60;
    localparam int          RANDOM_CYCLES    = 2000;
    localparam int          TAIL_COUNT       = 20;
    localparam int          MIN_REDIRECT_GAP = 6;
    localparam int          CYCLES_PER_INSTR = 16;
    localparam int          WATCHDOG_CYCLES  = RESET_CYCLES + 2 * STALL_CYCLES + RANDOM_CYCLES
                                               + (RUN_A_COUNT + 2 * TAIL_COUNT) * CYCLES_PER_INSTR
                                               + 1000;
    localparam logic [31:0] SEED             = 32'hccf9;
    localparam instr_t      DATA_KEY         = 32'ha5a5_5a5a;
    // Addresses answered with SLVERR
    localparam addr_t       ERR_LO           = 32'h1c00_0100;
    localparam addr_t       ERR_HI           = 32'h1c00_0110;
    // Unprivileged, secure, instruction access
    localparam logic [2:0]  PROT_INSTR_FETCH = 3'b100;

    logic        clk;
    logic        rst_i;
    logic        redirect_valid_i;
    addr_t       redirect_pc_i;
    addr_t       araddr_o;
    logic [2:0]  arprot_o;
    logic        arvalid_o;
    logic        arready_i = 1'b0;
    instr_t      rdata_i   = '0;
    axi_resp_t   rresp_i   = RESP_OKAY;
    logic        rvalid_i  = 1'b0;
    logic        rready_o;
    logic        instr_valid_o;
    addr_t       instr_pc_o;
    instr_t      instr_data_o;
    logic        instr_fault_o;
    logic        instr_ready_i;

    // Memory model state
    logic [31:0] mem_rng   = SEED;
    logic        r_pending = 1'b0;
    addr_t       r_addr    = '0;

    // Reference tracking, updated on the rising edge
    logic        ar_pending;
    logic        skip_ar;
    logic        grace;
    logic        expect_first;
    addr_t       target_q;
    addr_t       redir_target;
    addr_t       last_pc;
    addr_t       exp_pc;
    int          ar_since_pop;
    int          delivered;
    logic        ar_hs;
    logic        delivery;

    tb_clk_gen clk_gen_i (
        .clk_o (clk)
    );

    fetch_top fetch_top_i (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .araddr_o         (araddr_o),
        .arprot_o         (arprot_o),
        .arvalid_o        (arvalid_o),
        .arready_i        (arready_i),
        .rdata_i          (rdata_i),
        .rresp_i          (rresp_i),
        .rvalid_i         (rvalid_i),
        .rready_o         (rready_o),
        .instr_valid_o    (instr_valid_o),
        .instr_pc_o       (instr_pc_o),
        .instr_data_o     (instr_data_o),
        .instr_fault_o    (instr_fault_o),
        .instr_ready_i    (instr_ready_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic in_error_window(input addr_t addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // AXI slave with random AR and R delays, one read at a time
    always @(negedge clk) begin
        if (rst_i) begin
            arready_i <= 1'b0;
            rvalid_i  <= 1'b0;
            r_pending <= 1'b0;
        end else begin
            mem_rng = xorshift32(mem_rng);
            if (rvalid_i) begin
                // rready_o is high for the whole data phase
                rvalid_i  <= 1'b0;
                r_pending <= 1'b0;
            end else if (r_pending && mem_rng[1:0] != 2'b00) begin
                rvalid_i <= 1'b1;
                rdata_i  <= r_addr ^ DATA_KEY;
                rresp_i  <= in_error_window(r_addr) ? 2'b10 : RESP_OKAY;
            end
            if (arready_i) begin
                arready_i <= 1'b0;
                r_pending <= 1'b1;
            end else if (arvalid_o && !r_pending && mem_rng[3:2] != 2'b00) begin
                arready_i <= 1'b1;
                r_addr    <= araddr_o;
            end
        end
    end

    assign ar_hs    = arvalid_o && arready_i;
    assign delivery = instr_valid_o && instr_ready_i;
    assign exp_pc   = expect_first ? target_q : last_pc + PC_STEP;

    always @(posedge clk) begin
        if (rst_i) begin
            ar_pending   <= 1'b0;
            skip_ar      <= 1'b0;
            grace        <= 1'b0;
            expect_first <= 1'b1;
            target_q     <= RESET_PC;
            redir_target <= RESET_PC;
            last_pc      <= RESET_PC;
            ar_since_pop <= 0;
            delivered    <= 0;
        end else begin
            if (ar_hs) begin
                ar_pending <= 1'b1;
            end else if (rvalid_i && rready_o) begin
                ar_pending <= 1'b0;
            end
            // A read issued before the flush cycle never reaches the buffer
            if (grace) begin
                ar_since_pop <= 0;
                skip_ar      <= arvalid_o && !arready_i;
            end else if (ar_hs && skip_ar) begin
                skip_ar <= 1'b0;
            end else if (delivery) begin
                ar_since_pop <= ar_hs ? 1 : 0;
            end else if (ar_hs) begin
                ar_since_pop <= ar_since_pop + 1;
            end
            if (delivery) begin
                last_pc      <= instr_pc_o;
                expect_first <= 1'b0;
                delivered    <= delivered + 1;
            end
            // Old stream may still drain during the flush cycle
            grace <= redirect_valid_i;
            if (redirect_valid_i) begin
                redir_target <= {redirect_pc_i[31:2], 2'b00};
            end
            if (grace) begin
                expect_first <= 1'b1;
                target_q     <= redir_target;
            end
        end
    end

    assert property (@(posedge clk)
        $past(rst_i) |-> !arvalid_o && !rready_o && !instr_valid_o)
    else report_failure("AXI or backend valid active during or right after reset");

    assert property (@(posedge clk) disable iff (rst_i)
        $past(arvalid_o && !arready_i) |-> arvalid_o && $stable(araddr_o))
    else report_failure("AR channel changed before arready");

    assert property (@(posedge clk) disable iff (rst_i)
        arvalid_o |-> arprot_o == PROT_INSTR_FETCH)
    else report_mismatch($sformatf("arprot %b, expected %b",
                                   $sampled(arprot_o), PROT_INSTR_FETCH));

    assert property (@(posedge clk) disable iff (rst_i)
        arvalid_o |-> !ar_pending)
    else report_failure("new AR started before the R of the previous read");

    assert property (@(posedge clk) disable iff (rst_i)
        delivery |-> instr_pc_o == exp_pc)
    else report_mismatch($sformatf("instr pc %h, expected %h",
                                   $sampled(instr_pc_o), $sampled(exp_pc)));

    assert property (@(posedge clk) disable iff (rst_i)
        instr_valid_o |-> instr_data_o == (instr_pc_o ^ DATA_KEY))
    else report_mismatch($sformatf("instr data %h at pc %h",
                                   $sampled(instr_data_o), $sampled(instr_pc_o)));

    assert property (@(posedge clk) disable iff (rst_i)
        instr_valid_o |-> instr_fault_o == in_error_window(instr_pc_o))
    else report_mismatch($sformatf("fault %b at pc %h",
                                   $sampled(instr_fault_o), $sampled(instr_pc_o)));

    assert property (@(posedge clk) disable iff (rst_i)
        (instr_valid_o && $past(instr_valid_o && !instr_ready_i) && !$past(grace))
        |-> $stable(instr_pc_o) && $stable(instr_data_o) && $stable(instr_fault_o))
    else report_failure("backend outputs changed while stalled");

    assert property (@(posedge clk) disable iff (rst_i)
        ar_since_pop <= IBUF_DEPTH)
    else report_mismatch($sformatf("%0d reads since last delivery", $sampled(ar_since_pop)));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        report_failure("timeout, the test sequence did not finish");
    end

    initial begin
        logic [31:0] ctl_rng;
        int          stall_left;
        int          gap;
        int          mark;
        // Second stream from the same seed for backend and redirect control
        ctl_rng          = SEED ^ 32'h9e37_79b9;
        stall_left       = 0;
        gap              = 0;
        rst_i            = 1'b1;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_i = 1'b0;

        // Straight run through the error window
        while (delivered < RUN_A_COUNT) begin
            @(negedge clk);
            ctl_rng       = xorshift32(ctl_rng);
            instr_ready_i = (ctl_rng[2:0] != 3'b000);
        end

        // Fill the buffer, then redirect while full
        @(negedge clk);
        instr_ready_i = 1'b0;
        repeat (STALL_CYCLES) @(negedge clk);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = 32'h1c00_00f6;
        @(negedge clk);
        redirect_valid_i = 1'b0;
        repeat (STALL_CYCLES) @(negedge clk);
        instr_ready_i = 1'b1;
        mark          = delivered;
        while (delivered < mark + TAIL_COUNT) begin
            @(negedge clk);
        end

        // Random stalls and redirects
        for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
            @(negedge clk);
            ctl_rng = xorshift32(ctl_rng);
            if (stall_left > 0) begin
                instr_ready_i = 1'b0;
                stall_left--;
            end else if (ctl_rng[9:4] == 6'd0) begin
                instr_ready_i = 1'b0;
                stall_left    = 24 + int'(ctl_rng[15:11]);
            end else begin
                instr_ready_i = (ctl_rng[1:0] != 2'b00);
            end
            if (gap >= MIN_REDIRECT_GAP && ctl_rng[19:16] == 4'd0) begin
                redirect_valid_i = 1'b1;
                redirect_pc_i    = RESET_PC + addr_t'({ctl_rng[26:20], ctl_rng[28:27]});
                gap              = 0;
            end else begin
                redirect_valid_i = 1'b0;
                gap++;
            end
        end

        // Fetch must still make progress
        redirect_valid_i = 1'b0;
        instr_ready_i    = 1'b1;
        mark             = delivered;
        while (delivered < mark + TAIL_COUNT) begin
            @(negedge clk);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
source/fetch_pkg.sv
source/mem_read_if.sv
source/fetch_buf_if.sv
source/axi_read_master.sv
source/pc_gen.sv
source/instr_buffer.sv
source/fetch_top.sv
bench/tb_clk_gen.sv
bench/tb_fetch.sv

// ==== Makefile ====
TOP := tb_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "All tests passed" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
